/* source/cpu_macros.svh */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// datapath and storage sizes
`define CPU_XLEN        32
`define CPU_REG_AW      5
`define CPU_IMEM_DEPTH  64
`define CPU_DMEM_DEPTH  32

// loader byte codes
`define CPU_LOAD_START  8'hFE
`define CPU_LOAD_END    8'hFF

// major opcodes
`define OPC_RTYPE       7'b0110011
`define OPC_ITYPE       7'b0010011
`define OPC_LOAD        7'b0000011
`define OPC_STORE       7'b0100011
`define OPC_BRANCH      7'b1100011
`define OPC_VECTOR      7'b1010111

`endif

/* source/cpu_pkg.sv */
`include "cpu_macros.svh"

package cpu_pkg;

    typedef struct packed {
        logic [6:0]             funct7;
        logic [`CPU_REG_AW-1:0] rs2;
        logic [`CPU_REG_AW-1:0] rs1;
        logic [2:0]             funct3;
        logic [`CPU_REG_AW-1:0] rd;
        logic [6:0]             opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]            imm;
        logic [`CPU_REG_AW-1:0] rs1;
        logic [2:0]             funct3;
        logic [`CPU_REG_AW-1:0] rd;
        logic [6:0]             opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]             imm_hi;
        logic [`CPU_REG_AW-1:0] rs2;
        logic [`CPU_REG_AW-1:0] rs1;
        logic [2:0]             funct3;
        logic [4:0]             imm_lo;
        logic [6:0]             opcode;
    } s_fmt_t;

    typedef struct packed {
        logic                   imm12;
        logic [5:0]             imm10_5;
        logic [`CPU_REG_AW-1:0] rs2;
        logic [`CPU_REG_AW-1:0] rs1;
        logic [2:0]             funct3;
        logic [3:0]             imm4_1;
        logic                   imm11;
        logic [6:0]             opcode;
    } b_fmt_t;

    // same instruction word, viewed per format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
    } instr_u;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        VEC_ADD,
        VEC_SUB
    } alu_op_e;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    mem_to_reg;
        logic    alu_src;   // second operand is the immediate
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        logic                 valid;
        logic [`CPU_XLEN-1:0] pc;
        instr_u               instr;
    } fetch_t;

    typedef struct packed {
        logic                   valid;
        ctrl_t                  ctrl;
        logic [`CPU_REG_AW-1:0] rs1;
        logic [`CPU_REG_AW-1:0] rs2;
        logic [`CPU_REG_AW-1:0] rd;
        logic [`CPU_XLEN-1:0]   rs1_data;
        logic [`CPU_XLEN-1:0]   rs2_data;
        logic [`CPU_XLEN-1:0]   imm;
    } id_ex_t;

    typedef struct packed {
        logic                   valid;
        ctrl_t                  ctrl;
        logic [`CPU_REG_AW-1:0] rd;
        logic [`CPU_XLEN-1:0]   result;
        logic [`CPU_XLEN-1:0]   store_data;
    } ex_mem_t;

    // write-back bus
    typedef struct packed {
        logic                   valid;
        logic [`CPU_REG_AW-1:0] rd;
        logic [`CPU_XLEN-1:0]   data;
    } wb_t;

endpackage

/* source/fetch_stage.sv */
`timescale 1ns/1ps
`include "cpu_macros.svh"

module fetch_stage (
    input  logic                 clk_i,
    input  logic                 reset,
    input  logic [7:0]           load_byte_i,
    input  logic                 stall_i,
    input  logic                 redirect_i,
    input  logic [`CPU_XLEN-1:0] target_i,
    output cpu_pkg::fetch_t      if_id_o
);

    localparam int IMEM_AW = $clog2(`CPU_IMEM_DEPTH);

    logic                 load_mode;    // between FE and FF
    logic                 running;
    logic [1:0]           byte_cnt;
    logic [23:0]          word_buf;     // lower three bytes of the word being built
    logic [IMEM_AW-1:0]   wr_addr;
    logic [`CPU_XLEN-1:0] pc;
    logic [`CPU_XLEN-1:0] imem [`CPU_IMEM_DEPTH];
    logic [`CPU_XLEN-1:0] fetch_word;

    assign fetch_word = imem[pc[IMEM_AW+1:2]];  // word-aligned read

    // program loader, bytes arrive lsb first
    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            load_mode <= 1'b0;
            running   <= 1'b0;
            byte_cnt  <= '0;
            word_buf  <= '0;
            wr_addr   <= '0;
            for (int i = 0; i < `CPU_IMEM_DEPTH; i++) begin
                imem[i] <= '0;
            end
        end else if (load_mode) begin
            if (load_byte_i == `CPU_LOAD_END) begin
                load_mode <= 1'b0;
                running   <= 1'b1;          // stays high until reset
            end else begin
                byte_cnt <= byte_cnt + 2'd1;
                word_buf <= {load_byte_i, word_buf[23:8]};
                if (byte_cnt == 2'd3) begin
                    imem[wr_addr] <= {load_byte_i, word_buf};
                    wr_addr       <= wr_addr + 1'b1;
                end
            end
        end else if (!running && load_byte_i == `CPU_LOAD_START) begin
            load_mode <= 1'b1;
            byte_cnt  <= '0;
            wr_addr   <= '0;
        end
    end

    // pc and IF/ID register
    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            pc      <= '0;
            if_id_o <= '0;
        end else if (!running) begin
            pc      <= '0;                  // held until FF
            if_id_o <= '0;
        end else if (redirect_i) begin
            pc      <= target_i;
            if_id_o <= '0;                  // flush the wrong-path fetch
        end else if (!stall_i) begin
            pc            <= pc + `CPU_XLEN'd4;
            if_id_o.valid <= 1'b1;
            if_id_o.pc    <= pc;
            if_id_o.instr <= fetch_word;
        end
    end

endmodule

/* source/register_file.sv */
`timescale 1ns/1ps
`include "cpu_macros.svh"

module register_file (
    input  logic                   clk_i,
    input  logic                   reset,
    input  logic [`CPU_REG_AW-1:0] rs1_addr_i,
    input  logic [`CPU_REG_AW-1:0] rs2_addr_i,
    input  cpu_pkg::wb_t           wb_i,
    input  logic [`CPU_REG_AW-1:0] dbg_addr_i,
    output logic [`CPU_XLEN-1:0]   rs1_data_o,
    output logic [`CPU_XLEN-1:0]   rs2_data_o,
    output logic [`CPU_XLEN-1:0]   dbg_data_o
);

    logic [`CPU_XLEN-1:0] regs [2**`CPU_REG_AW];
    logic                 wr_en;

    assign wr_en = wb_i.valid && (wb_i.rd != '0);   // x0 never written

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 2**`CPU_REG_AW; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    // write-through so decode sees this cycle's write-back
    assign rs1_data_o = (wr_en && wb_i.rd == rs1_addr_i) ? wb_i.data : regs[rs1_addr_i];
    assign rs2_data_o = (wr_en && wb_i.rd == rs2_addr_i) ? wb_i.data : regs[rs2_addr_i];
    assign dbg_data_o = regs[dbg_addr_i];

endmodule

/* source/decode_stage.sv */
`timescale 1ns/1ps
`include "cpu_macros.svh"

module decode_stage (
    input  logic                   clk_i,
    input  logic                   reset,
    input  cpu_pkg::fetch_t        if_id_i,
    input  cpu_pkg::wb_t           wb_i,
    input  logic [`CPU_REG_AW-1:0] dbg_addr_i,
    output cpu_pkg::id_ex_t        id_ex_o,
    output logic                   stall_o,
    output logic                   redirect_o,
    output logic [`CPU_XLEN-1:0]   target_o,
    output logic [`CPU_XLEN-1:0]   dbg_reg_o
);

    cpu_pkg::instr_u      instr;
    cpu_pkg::ctrl_t       ctrl;
    logic [6:0]           opcode;
    logic [`CPU_XLEN-1:0] rs1_data;
    logic [`CPU_XLEN-1:0] rs2_data;
    logic [`CPU_XLEN-1:0] imm;
    logic [`CPU_XLEN-1:0] b_offset;
    logic                 uses_rs2;
    logic                 load_hazard;
    logic                 is_beq;

    assign instr  = if_id_i.instr;
    assign opcode = instr.r.opcode;

    register_file u_regs (
        .clk_i      (clk_i),
        .reset      (reset),
        .rs1_addr_i (instr.r.rs1),
        .rs2_addr_i (instr.r.rs2),
        .wb_i       (wb_i),
        .dbg_addr_i (dbg_addr_i),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .dbg_data_o (dbg_reg_o)
    );

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = cpu_pkg::ALU_ADD;
        case (opcode)
            `OPC_RTYPE: begin
                ctrl.reg_write = 1'b1;
                case (instr.r.funct3)
                    3'b111:  ctrl.alu_op = cpu_pkg::ALU_AND;
                    3'b110:  ctrl.alu_op = cpu_pkg::ALU_OR;
                    default: ctrl.alu_op = instr.r.funct7[5] ? cpu_pkg::ALU_SUB
                                                             : cpu_pkg::ALU_ADD;
                endcase
            end
            `OPC_ITYPE: begin                   // addi only
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            `OPC_LOAD: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.alu_src    = 1'b1;
            end
            `OPC_STORE: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            `OPC_VECTOR: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = instr.r.funct7[5] ? cpu_pkg::VEC_SUB : cpu_pkg::VEC_ADD;
            end
            default: ;                          // branch and zero word write nothing
        endcase
    end

    // S view for stores, I view otherwise
    assign imm = (opcode == `OPC_STORE) ?
                 {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo} :
                 {{20{instr.i.imm[11]}}, instr.i.imm};

    assign b_offset = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                       instr.b.imm10_5, instr.b.imm4_1, 1'b0};

    assign uses_rs2 = (opcode == `OPC_RTYPE) || (opcode == `OPC_STORE) ||
                      (opcode == `OPC_BRANCH) || (opcode == `OPC_VECTOR);

    // load in EX whose result is needed right now
    assign load_hazard = id_ex_o.valid && id_ex_o.ctrl.mem_read && (id_ex_o.rd != '0) &&
                         ((id_ex_o.rd == instr.r.rs1) ||
                          (uses_rs2 && id_ex_o.rd == instr.r.rs2));
    assign stall_o = if_id_i.valid && load_hazard;

    assign is_beq     = (opcode == `OPC_BRANCH) && (instr.b.funct3 == 3'b000);
    assign redirect_o = if_id_i.valid && is_beq && (rs1_data == rs2_data) && !stall_o;
    assign target_o   = if_id_i.pc + b_offset;

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            id_ex_o <= '0;
        end else if (stall_o || !if_id_i.valid) begin
            id_ex_o <= '0;                      // bubble
        end else begin
            id_ex_o.valid    <= 1'b1;
            id_ex_o.ctrl     <= ctrl;
            id_ex_o.rs1      <= instr.r.rs1;
            id_ex_o.rs2      <= instr.r.rs2;
            id_ex_o.rd       <= instr.r.rd;
            id_ex_o.rs1_data <= rs1_data;
            id_ex_o.rs2_data <= rs2_data;
            id_ex_o.imm      <= imm;
        end
    end

endmodule

/* source/execute_stage.sv */
`timescale 1ns/1ps
`include "cpu_macros.svh"

module execute_stage (
    input  logic             clk_i,
    input  logic             reset,
    input  cpu_pkg::id_ex_t  id_ex_i,
    input  cpu_pkg::wb_t     wb_i,
    output cpu_pkg::ex_mem_t ex_mem_o
);

    logic [`CPU_XLEN-1:0] fwd_a;
    logic [`CPU_XLEN-1:0] fwd_b;
    logic [`CPU_XLEN-1:0] op_b;
    logic [`CPU_XLEN-1:0] result;
    logic                 mem_fwd_ok;
    logic                 wb_fwd_ok;

    // four independent byte lanes, carries do not cross
    function automatic logic [`CPU_XLEN-1:0] lane_math(
        input logic [`CPU_XLEN-1:0] a,
        input logic [`CPU_XLEN-1:0] b,
        input logic                 sub
    );
        logic [`CPU_XLEN-1:0] r;
        for (int k = 0; k < `CPU_XLEN / 8; k++) begin
            r[8*k +: 8] = sub ? a[8*k +: 8] - b[8*k +: 8] : a[8*k +: 8] + b[8*k +: 8];
        end
        return r;
    endfunction

    assign mem_fwd_ok = ex_mem_o.valid && ex_mem_o.ctrl.reg_write && (ex_mem_o.rd != '0);
    assign wb_fwd_ok  = wb_i.valid && (wb_i.rd != '0);

    // EX/MEM is younger, so it wins
    always_comb begin
        if (mem_fwd_ok && ex_mem_o.rd == id_ex_i.rs1) begin
            fwd_a = ex_mem_o.result;
        end else if (wb_fwd_ok && wb_i.rd == id_ex_i.rs1) begin
            fwd_a = wb_i.data;
        end else begin
            fwd_a = id_ex_i.rs1_data;
        end

        if (mem_fwd_ok && ex_mem_o.rd == id_ex_i.rs2) begin
            fwd_b = ex_mem_o.result;
        end else if (wb_fwd_ok && wb_i.rd == id_ex_i.rs2) begin
            fwd_b = wb_i.data;
        end else begin
            fwd_b = id_ex_i.rs2_data;
        end
    end

    assign op_b = id_ex_i.ctrl.alu_src ? id_ex_i.imm : fwd_b;

    always_comb begin
        case (id_ex_i.ctrl.alu_op)
            cpu_pkg::ALU_SUB: result = fwd_a - op_b;
            cpu_pkg::ALU_AND: result = fwd_a & op_b;
            cpu_pkg::ALU_OR:  result = fwd_a | op_b;
            cpu_pkg::VEC_ADD: result = lane_math(fwd_a, op_b, 1'b0);
            cpu_pkg::VEC_SUB: result = lane_math(fwd_a, op_b, 1'b1);
            default:          result = fwd_a + op_b;   // add, addresses
        endcase
    end

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            ex_mem_o <= '0;
        end else begin
            ex_mem_o.valid      <= id_ex_i.valid;
            ex_mem_o.ctrl       <= id_ex_i.valid ? id_ex_i.ctrl : '0;
            ex_mem_o.rd         <= id_ex_i.rd;
            ex_mem_o.result     <= result;
            ex_mem_o.store_data <= fwd_b;           // forwarded for sw
        end
    end

endmodule

/* source/memory_stage.sv */
`timescale 1ns/1ps
`include "cpu_macros.svh"

module memory_stage (
    input  logic                   clk_i,
    input  logic                   reset,
    input  cpu_pkg::ex_mem_t       ex_mem_i,
    input  logic [`CPU_REG_AW-1:0] dbg_addr_i,
    output cpu_pkg::wb_t           wb_o,
    output logic [`CPU_XLEN-1:0]   dbg_data_o
);

    localparam int DMEM_AW = $clog2(`CPU_DMEM_DEPTH);

    logic [`CPU_XLEN-1:0] dmem [`CPU_DMEM_DEPTH];
    logic [DMEM_AW-1:0]   word_addr;
    logic [`CPU_XLEN-1:0] read_data;

    assign word_addr  = ex_mem_i.result[DMEM_AW+1:2];   // byte address to word index
    assign read_data  = dmem[word_addr];
    assign dbg_data_o = dmem[dbg_addr_i[DMEM_AW-1:0]];

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `CPU_DMEM_DEPTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (ex_mem_i.valid && ex_mem_i.ctrl.mem_write) begin
            dmem[word_addr] <= ex_mem_i.store_data;
        end
    end

    // MEM/WB register, drives the write-back bus
    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            wb_o <= '0;
        end else begin
            wb_o.valid <= ex_mem_i.valid && ex_mem_i.ctrl.reg_write;
            wb_o.rd    <= ex_mem_i.rd;
            wb_o.data  <= ex_mem_i.ctrl.mem_to_reg ? read_data : ex_mem_i.result;
        end
    end

endmodule

/* source/cpu_top.sv */
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_top (
    input  logic                   clk_i,
    input  logic                   reset,
    input  logic [7:0]             instr_i,
    input  logic                   reg_sel_i,
    input  logic [`CPU_REG_AW-1:0] address_i,
    input  logic [1:0]             byte_sel_i,
    output logic [7:0]             value_o
);

    cpu_pkg::fetch_t      if_id;
    cpu_pkg::id_ex_t      id_ex;
    cpu_pkg::ex_mem_t     ex_mem;
    cpu_pkg::wb_t         wb;
    logic                 stall;
    logic                 redirect;
    logic [`CPU_XLEN-1:0] target;
    logic [`CPU_XLEN-1:0] dbg_reg;
    logic [`CPU_XLEN-1:0] dbg_mem;
    logic [`CPU_XLEN-1:0] dbg_word;

    fetch_stage u_fetch (
        .clk_i       (clk_i),
        .reset       (reset),
        .load_byte_i (instr_i),
        .stall_i     (stall),
        .redirect_i  (redirect),
        .target_i    (target),
        .if_id_o     (if_id)
    );

    decode_stage u_decode (
        .clk_i      (clk_i),
        .reset      (reset),
        .if_id_i    (if_id),
        .wb_i       (wb),
        .dbg_addr_i (address_i),
        .id_ex_o    (id_ex),
        .stall_o    (stall),
        .redirect_o (redirect),
        .target_o   (target),
        .dbg_reg_o  (dbg_reg)
    );

    execute_stage u_execute (
        .clk_i    (clk_i),
        .reset    (reset),
        .id_ex_i  (id_ex),
        .wb_i     (wb),
        .ex_mem_o (ex_mem)
    );

    memory_stage u_memory (
        .clk_i      (clk_i),
        .reset      (reset),
        .ex_mem_i   (ex_mem),
        .dbg_addr_i (address_i),
        .wb_o       (wb),
        .dbg_data_o (dbg_mem)
    );

    // debug readout, register file or data memory
    assign dbg_word = reg_sel_i ? dbg_reg : dbg_mem;
    assign value_o  = dbg_word[8*byte_sel_i +: 8];

endmodule

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 100
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;   // toggle every half period
    end

endmodule

/* testbench/cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb;

    localparam logic [31:0] SEED         = 32'h44b7_59ed;
    localparam int          READ_TIMEOUT = 200;
    localparam logic [6:0]  OP_R         = 7'b0110011;
    localparam logic [6:0]  OP_I         = 7'b0010011;
    localparam logic [6:0]  OP_LD        = 7'b0000011;
    localparam logic [6:0]  OP_ST        = 7'b0100011;
    localparam logic [6:0]  OP_BR        = 7'b1100011;
    localparam logic [6:0]  OP_V         = 7'b1010111;
    localparam logic [6:0]  F7_SUB       = 7'b0100000;

    logic        clk;
    logic        reset;
    logic [7:0]  instr_i;
    logic        reg_sel_i;
    logic [4:0]  address_i;
    logic [1:0]  byte_sel_i;
    logic [7:0]  value_o;
    logic [31:0] program_words [$];

    tb_clock_gen #(.PERIOD_NS(100)) clock_gen (.clk_o(clk));

    cpu_top UUT (
        .clk_i      (clk),
        .reset      (reset),
        .instr_i    (instr_i),
        .reg_sel_i  (reg_sel_i),
        .address_i  (address_i),
        .byte_sel_i (byte_sel_i),
        .value_o    (value_o)
    );

    // instruction encoders
    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] add_word(input logic [4:0] rd, rs1, rs2);
        return r_word(7'd0, 3'b000, rd, rs1, rs2, OP_R);
    endfunction

    function automatic logic [31:0] sub_word(input logic [4:0] rd, rs1, rs2);
        return r_word(F7_SUB, 3'b000, rd, rs1, rs2, OP_R);
    endfunction

    function automatic logic [31:0] and_word(input logic [4:0] rd, rs1, rs2);
        return r_word(7'd0, 3'b111, rd, rs1, rs2, OP_R);
    endfunction

    function automatic logic [31:0] or_word(input logic [4:0] rd, rs1, rs2);
        return r_word(7'd0, 3'b110, rd, rs1, rs2, OP_R);
    endfunction

    function automatic logic [31:0] vadd_word(input logic [4:0] rd, rs1, rs2);
        return r_word(7'd0, 3'b000, rd, rs1, rs2, OP_V);
    endfunction

    function automatic logic [31:0] vsub_word(input logic [4:0] rd, rs1, rs2);
        return r_word(F7_SUB, 3'b000, rd, rs1, rs2, OP_V);
    endfunction

    function automatic logic [31:0] addi_word(input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, OP_I};
    endfunction

    function automatic logic [31:0] lw_word(input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, OP_LD};
    endfunction

    function automatic logic [31:0] sw_word(input logic [4:0] rs2, rs1, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_ST};
    endfunction

    function automatic logic [31:0] beq_word(input logic [4:0] rs1, rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], OP_BR};
    endfunction

    function automatic bit has_ff(input logic [31:0] w);
        return (w[7:0] == 8'hFF) || (w[15:8] == 8'hFF) ||
               (w[23:16] == 8'hFF) || (w[31:24] == 8'hFF);
    endfunction

    // positive immediate whose addi encoding never hits the end byte
    function automatic logic [11:0] draw_addi_imm(input logic [4:0] rd);
        logic [11:0] imm;
        imm = 12'(1 + ($urandom % 2047));
        while (has_ff(addi_word(rd, 5'd0, imm))) begin
            imm = 12'(1 + ($urandom % 2047));
        end
        return imm;
    endfunction

    // each 8-bit lane wraps modulo 256
    function automatic logic [31:0] lane_ref(input logic [31:0] a, input logic [31:0] b,
                                             input bit sub);
        logic [31:0] r;
        int          x;
        int          y;
        for (int k = 0; k < 4; k++) begin
            x = int'(a[8*k +: 8]);
            y = int'(b[8*k +: 8]);
            r[8*k +: 8] = 8'((sub ? x - y + 256 : x + y) % 256);
        end
        return r;
    endfunction

    task automatic stop_on_failure();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        if (got !== expected) begin
            $display("ERR @%0t: %s got %h expected %h", $time, what, got, expected);
            stop_on_failure();
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        reset   = 1'b1;
        instr_i = 8'h00;
        repeat (16) @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic load_program();
        foreach (program_words[w]) begin
            if (has_ff(program_words[w])) begin
                $display("program word %0d contains the end byte and cannot be loaded", w);
                stop_on_failure();
            end
        end
        apply_reset();
        instr_i = 8'hFE;                          // enter load mode
        foreach (program_words[w]) begin
            for (int k = 0; k < 4; k++) begin
                @(negedge clk);
                instr_i = program_words[w][8*k +: 8]; // lsb first
            end
        end
        @(negedge clk);
        instr_i = 8'hFF;                          // start running
        @(negedge clk);
        instr_i = 8'h00;
    endtask

    // one byte per cycle, sampled at the next falling edge
    task automatic read_word(input logic sel, input logic [4:0] addr, output logic [31:0] word);
        @(negedge clk);
        reg_sel_i  = sel;
        address_i  = addr;
        byte_sel_i = 2'd0;
        for (int k = 0; k < 4; k++) begin
            @(negedge clk);
            word[8*k +: 8] = value_o;
            byte_sel_i     = 2'(k + 1);
        end
    endtask

    task automatic await_word(input logic sel, input logic [4:0] addr,
                              input logic [31:0] expected, input string what);
        logic [31:0] got;
        int          waited;
        waited = 0;
        read_word(sel, addr, got);
        while (got !== expected && waited < READ_TIMEOUT) begin
            read_word(sel, addr, got);
            waited += 5;                          // a read spans five cycles
        end
        if (got !== expected) begin
            $display("timeout: %s never showed the expected value within %0d cycles",
                     what, READ_TIMEOUT);
        end
        check_value(got, expected, what);
    endtask

    task automatic read_reg(input logic [4:0] addr, input logic [31:0] expected);
        await_word(1'b1, addr, expected, $sformatf("register x%0d", addr));
    endtask

    task automatic read_mem(input logic [4:0] addr, input logic [31:0] expected);
        await_word(1'b0, addr, expected, $sformatf("data word %0d", addr));
    endtask

    task automatic reset_clears_state();
        logic [31:0] got;
        apply_reset();
        for (int a = 0; a < 32; a++) begin
            read_word(1'b1, 5'(a), got);
            check_value(got, 32'd0, $sformatf("x%0d after reset", a));
            read_word(1'b0, 5'(a), got);
            check_value(got, 32'd0, $sformatf("data word %0d after reset", a));
        end
    endtask

    task automatic scalar_alu_ops();
        logic [31:0] a;
        logic [31:0] b;
        a = {20'd0, draw_addi_imm(5'd1)};
        b = {20'd0, draw_addi_imm(5'd2)};
        program_words.delete();
        program_words.push_back(addi_word(5'd1, 5'd0, a[11:0]));
        program_words.push_back(addi_word(5'd2, 5'd0, b[11:0]));
        repeat (3) program_words.push_back(32'd0);   // operands settle in the register file
        program_words.push_back(add_word(5'd3, 5'd1, 5'd2));
        program_words.push_back(sub_word(5'd4, 5'd1, 5'd2));
        program_words.push_back(and_word(5'd5, 5'd1, 5'd2));
        program_words.push_back(or_word(5'd6, 5'd1, 5'd2));
        load_program();
        read_reg(5'd3, a + b);
        read_reg(5'd4, a - b);
        read_reg(5'd5, a & b);
        read_reg(5'd6, a | b);
    endtask

    task automatic forwarding_chain();
        logic [31:0] r [1:8];
        r[1] = 32'd300;
        r[2] = 32'd1234;
        r[3] = r[1] + r[2];
        r[4] = r[3] - r[1];
        r[5] = r[4] + r[3];
        r[6] = r[5] - r[2];
        r[7] = r[6] + r[5];
        r[8] = r[1] - r[7];                       // wraps below zero
        program_words.delete();
        program_words.push_back(addi_word(5'd1, 5'd0, 12'd300));
        program_words.push_back(addi_word(5'd2, 5'd0, 12'd1234));
        program_words.push_back(add_word(5'd3, 5'd1, 5'd2));
        program_words.push_back(sub_word(5'd4, 5'd3, 5'd1));
        program_words.push_back(add_word(5'd5, 5'd4, 5'd3));
        program_words.push_back(sub_word(5'd6, 5'd5, 5'd2));
        program_words.push_back(add_word(5'd7, 5'd6, 5'd5));
        program_words.push_back(sub_word(5'd8, 5'd1, 5'd7));
        load_program();
        for (int i = 3; i <= 8; i++) begin
            read_reg(5'(i), r[i]);
        end
    endtask

    task automatic memory_and_load_use();
        logic [31:0] v1;
        logic [31:0] v2;
        logic [31:0] v3;
        v1 = 32'h123;
        v2 = 32'h5A5;
        v3 = 32'h7F0;
        program_words.delete();
        program_words.push_back(addi_word(5'd1, 5'd0, v1[11:0]));
        program_words.push_back(addi_word(5'd2, 5'd0, v2[11:0]));
        program_words.push_back(addi_word(5'd3, 5'd0, v3[11:0]));
        program_words.push_back(sw_word(5'd1, 5'd0, 12'd0));
        program_words.push_back(sw_word(5'd2, 5'd0, 12'd8));
        program_words.push_back(sw_word(5'd3, 5'd0, 12'd20));
        program_words.push_back(sw_word(5'd2, 5'd0, 12'd124));
        program_words.push_back(lw_word(5'd4, 5'd0, 12'd8));
        program_words.push_back(add_word(5'd5, 5'd4, 5'd1));  // needs the loaded value
        load_program();
        read_mem(5'd0, v1);
        read_mem(5'd2, v2);
        read_mem(5'd5, v3);
        read_mem(5'd31, v2);
        read_reg(5'd4, v2);
        read_reg(5'd5, v2 + v1);
    endtask

    task automatic branch_skip(input bit taken);
        logic [31:0] got;
        logic [11:0] second;
        second = taken ? 12'd55 : 12'd66;
        program_words.delete();
        program_words.push_back(addi_word(5'd1, 5'd0, 12'd55));
        program_words.push_back(addi_word(5'd2, 5'd0, second));
        repeat (2) program_words.push_back(32'd0);  // branch reads x2 three slots later
        program_words.push_back(beq_word(5'd1, 5'd2, 13'd8));
        program_words.push_back(addi_word(5'd9, 5'd0, 12'd99));   // marker
        program_words.push_back(addi_word(5'd10, 5'd0, 12'd77));
        load_program();
        read_reg(5'd10, 32'd77);
        read_word(1'b1, 5'd9, got);
        check_value(got, taken ? 32'd0 : 32'd99,
                    taken ? "marker x9 after taken beq" : "marker x9 after not-taken beq");
    endtask

    task automatic vector_lane_wrap();
        logic [31:0] r [1:8];
        logic [31:0] got;
        r[1] = 32'd257;
        r[2] = 32'd1731;
        r[3] = 32'd0 - r[1];
        r[4] = r[3] + r[3];
        r[5] = lane_ref(r[3], r[2], 1'b0);
        r[6] = lane_ref(r[2], r[4], 1'b1);
        r[7] = lane_ref(r[4], r[3], 1'b0);
        r[8] = lane_ref(r[1], r[2], 1'b1);
        program_words.delete();
        program_words.push_back(addi_word(5'd1, 5'd0, 12'd257));
        program_words.push_back(addi_word(5'd2, 5'd0, 12'd1731));
        program_words.push_back(sub_word(5'd3, 5'd0, 5'd1));
        program_words.push_back(add_word(5'd4, 5'd3, 5'd3));
        program_words.push_back(vadd_word(5'd5, 5'd3, 5'd2));
        program_words.push_back(vsub_word(5'd6, 5'd2, 5'd4));
        program_words.push_back(vadd_word(5'd7, 5'd4, 5'd3));
        program_words.push_back(vsub_word(5'd8, 5'd1, 5'd2));
        load_program();
        read_reg(5'd8, r[8]);                     // last write of the program
        for (int i = 5; i <= 7; i++) begin
            read_word(1'b1, 5'(i), got);
            for (int k = 0; k < 4; k++) begin
                check_value({24'd0, got[8*k +: 8]}, {24'd0, r[i][8*k +: 8]},
                            $sformatf("x%0d lane %0d", i, k));
            end
        end
    endtask

    initial begin
        void'($urandom(SEED));
        reset      = 1'b1;
        instr_i    = 8'h00;
        reg_sel_i  = 1'b0;
        address_i  = 5'd0;
        byte_sel_i = 2'd0;
        scalar_alu_ops();
        forwarding_chain();
        memory_and_load_use();
        reset_clears_state();                     // registers and memory hold data here
        branch_skip(1'b1);
        branch_skip(1'b0);
        vector_lane_wrap();
        $display("TEST PASSED");
        $finish;
    end

endmodule

/* cpu_top.f */
+incdir+source
source/cpu_pkg.sv
source/fetch_stage.sv
source/register_file.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/cpu_top.sv
testbench/tb_clock_gen.sv
testbench/cpu_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := cpu_tb
FILELIST  := cpu_top.f

OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard source/*.sv source/*.svh testbench/*.sv)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)
